// ==== logic/mdio_pkg.sv ====
package mdio_pkg;

	////////////////////
	// MDC pacing

	// apb cycles per MDC half period
	localparam int mdc_half_period = 4;
	localparam int div_count_width = $clog2(mdc_half_period);
	localparam logic [div_count_width-1:0] div_last = div_count_width'(mdc_half_period - 1);

	////////////////////
	// Frame geometry

	localparam int preamble_bits = 32;
	localparam int frame_bits = 32;
	localparam int reg_data_width = 16;
	localparam int bit_count_width = $clog2(preamble_bits);
	localparam int cap_count_width = $clog2(reg_data_width);

	// Last preamble fall, then load
	localparam logic [bit_count_width-1:0] preamble_last = bit_count_width'(preamble_bits - 1);
	// Fall that puts the final frame bit on the wire
	localparam logic [bit_count_width-1:0] frame_shift_last = bit_count_width'(frame_bits - 2);
	// Bit positions in send order
	localparam logic [bit_count_width-1:0] ta_first_bit = bit_count_width'(14);
	localparam logic [bit_count_width-1:0] data_first_bit = bit_count_width'(16);
	localparam logic [cap_count_width-1:0] cap_last = cap_count_width'(reg_data_width - 1);

	////////////////////
	// APB side

	localparam int addr_width = 8;
	localparam int data_width = 32;

	// Offsets on 32 byte steps
	localparam logic [addr_width-1:0] reg_cmd_addr = 8'h00;
	localparam logic [addr_width-1:0] reg_data = 8'h20;
	localparam logic [addr_width-1:0] reg_status = 8'h40;
	localparam logic [addr_width-1:0] reg_status2 = 8'h60;

	////////////////////
	// Clause 22 codes

	localparam logic [1:0] start_code = 2'b01;
	localparam logic [1:0] ta_code = 2'b10;
	localparam logic [1:0] op_read = 2'b10;
	localparam logic [1:0] op_write = 2'b01;

	// FSM state codes
	localparam logic [1:0] fsm_idle = 2'd0;
	localparam logic [1:0] fsm_preamble = 2'd1;
	localparam logic [1:0] fsm_frame = 2'd2;
	localparam logic [1:0] fsm_finish = 2'd3;

	// Frame in send order, MSB first
	typedef struct packed {
		logic [1:0] start;
		logic [1:0] op;
		logic [4:0] phy_addr;
		logic [4:0] reg_addr;
		logic [1:0] ta;
		logic [reg_data_width-1:0] data;
	} mdio_frame_fields_t;

	// Same word as fields or as raw shift data
	typedef union packed {
		mdio_frame_fields_t fields;
		logic [frame_bits-1:0] raw;
	} mdio_frame_u;

endpackage

// ==== logic/mdio_clock_divider.sv ====
`timescale 1ns/100ps

module mdio_clock_divider (
	input logic apb,
	input logic arst_n,
	input logic restart,
	output logic mdc,
	output logic mdc_rise,
	output logic mdc_fall
);

	// Half period counter
	logic [mdio_pkg::div_count_width-1:0] div_cnt;
	// Last cycle of a half period
	logic wrap;

	// No ticks while held in restart
	assign wrap = (div_cnt == mdio_pkg::div_last) && !restart;

	// Ticks lead the mdc edge by one register stage
	assign mdc_rise = wrap && !mdc;
	assign mdc_fall = wrap && mdc;

	always_ff @(posedge apb or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= '0;
			mdc <= 1'b0;
		end else if (restart) begin
			// Clean phase for the next frame
			div_cnt <= '0;
			mdc <= 1'b0;
		end else if (wrap) begin
			div_cnt <= '0;
			mdc <= ~mdc;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	////////////////////
	// Checks

	// Every fall comes one half period after a rise
	a_half_period: assert property (@(posedge apb) disable iff (!arst_n)
		mdc_fall |-> $past(mdc_rise, mdio_pkg::mdc_half_period));

endmodule

// ==== logic/mdio_frame_fsm.sv ====
`timescale 1ns/100ps

module mdio_frame_fsm (
	input logic apb,
	input logic arst_n,
	input logic start_read,
	input logic start_write,
	input logic mdc_rise,
	input logic mdc_fall,
	output logic restart,
	output logic busy,
	output logic load,
	output logic shift,
	output logic capture,
	output logic mdio_oe
);

	logic [1:0] state;
	// Counts MDC falls inside preamble and frame
	logic [mdio_pkg::bit_count_width-1:0] bit_cnt;
	// Operation latched at start
	logic op_is_read;
	// Wire handed to the PHY
	logic released;
	// Read data on the wire
	logic rx_window;

	////////////////////
	// State and counter

	always_ff @(posedge apb or negedge arst_n) begin
		if (!arst_n) begin
			state <= mdio_pkg::fsm_idle;
			bit_cnt <= '0;
			op_is_read <= 1'b0;
		end else begin
			case (state)
				mdio_pkg::fsm_idle: begin
					if (start_read || start_write) begin
						state <= mdio_pkg::fsm_preamble;
						bit_cnt <= '0;
						op_is_read <= start_read;
					end
				end
				mdio_pkg::fsm_preamble: begin
					// Frame word loads on the last preamble fall
					if (mdc_fall) begin
						if (bit_cnt == mdio_pkg::preamble_last) begin
							state <= mdio_pkg::fsm_frame;
							bit_cnt <= '0;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				mdio_pkg::fsm_frame: begin
					// bit_cnt is the bit now on the wire
					if (mdc_fall) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == mdio_pkg::frame_shift_last)
							state <= mdio_pkg::fsm_finish;
					end
				end
				mdio_pkg::fsm_finish: begin
					// Final bit sampled on this rise, done at next fall
					if (mdc_fall)
						state <= mdio_pkg::fsm_idle;
				end
				default: begin
					state <= mdio_pkg::fsm_idle;
				end
			endcase
		end
	end

	////////////////////
	// Outputs

	assign busy = (state != mdio_pkg::fsm_idle);
	// Divider sits at phase zero between frames
	assign restart = (state == mdio_pkg::fsm_idle);

	assign load = (state == mdio_pkg::fsm_preamble) && mdc_fall &&
		(bit_cnt == mdio_pkg::preamble_last);
	// Last shift in finish refills the word with ones
	assign shift = mdc_fall &&
		((state == mdio_pkg::fsm_frame) || (state == mdio_pkg::fsm_finish));

	// Turnaround onward
	assign released = (state == mdio_pkg::fsm_finish) ||
		((state == mdio_pkg::fsm_frame) && (bit_cnt >= mdio_pkg::ta_first_bit));
	// Sixteen data bits
	assign rx_window = (state == mdio_pkg::fsm_finish) ||
		((state == mdio_pkg::fsm_frame) && (bit_cnt >= mdio_pkg::data_first_bit));

	assign capture = mdc_rise && op_is_read && rx_window;
	assign mdio_oe = busy && !(op_is_read && released);

	////////////////////
	// Checks

	// Register block refuses commands while busy
	a_start_idle: assert property (@(posedge apb) disable iff (!arst_n)
		(start_read || start_write) |-> (state == mdio_pkg::fsm_idle));

endmodule

// ==== logic/mdio_shift_reg.sv ====
`timescale 1ns/100ps

module mdio_shift_reg (
	input logic apb,
	input logic arst_n,
	input mdio_pkg::mdio_frame_u frame,
	input logic load,
	input logic shift,
	input logic capture,
	input logic mdio_in,
	output logic mdio_out,
	output logic [mdio_pkg::reg_data_width-1:0] rd_data
);

	////////////////////
	// Transmit

	// All ones when not loaded, so idle gives the preamble
	logic [mdio_pkg::frame_bits-1:0] tx_sr;

	always_ff @(posedge apb or negedge arst_n) begin
		if (!arst_n) begin
			tx_sr <= '1;
		end else if (load) begin
			tx_sr <= frame.raw;
		end else if (shift) begin
			// Ones fill in behind the frame
			tx_sr <= {tx_sr[mdio_pkg::frame_bits-2:0], 1'b1};
		end
	end

	// MSB first on the wire
	assign mdio_out = tx_sr[mdio_pkg::frame_bits-1];

	////////////////////
	// Receive

	// Bits in flight
	logic [mdio_pkg::reg_data_width-1:0] rx_sr;
	// Captures so far, wraps every word
	logic [mdio_pkg::cap_count_width-1:0] cap_cnt;

	always_ff @(posedge apb) begin
		if (capture)
			rx_sr <= {rx_sr[mdio_pkg::reg_data_width-2:0], mdio_in};
	end

	always_ff @(posedge apb or negedge arst_n) begin
		if (!arst_n) begin
			cap_cnt <= '0;
			rd_data <= '0;
		end else if (capture) begin
			cap_cnt <= cap_cnt + 1'b1;
			// Publish only a complete word
			if (cap_cnt == mdio_pkg::cap_last)
				rd_data <= {rx_sr[mdio_pkg::reg_data_width-2:0], mdio_in};
		end
	end

endmodule

// ==== logic/apb_mdio_regs.sv ====
`timescale 1ns/100ps

module apb_mdio_regs (
	input logic apb,
	input logic arst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [mdio_pkg::addr_width-1:0] paddr,
	input logic [mdio_pkg::data_width-1:0] pwdata,
	output logic [mdio_pkg::data_width-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic busy,
	input logic [mdio_pkg::reg_data_width-1:0] rd_data,
	output mdio_pkg::mdio_frame_u frame,
	output logic start_read,
	output logic start_write
);

	// Access phase
	logic access;
	// Write that takes effect
	logic wr_ok;
	logic [4:0] phy_addr;
	logic [4:0] reg_addr;
	logic [mdio_pkg::reg_data_width-1:0] wr_data;
	// Opcode of the pending frame
	logic [1:0] cmd_op;

	// No wait states
	assign access = psel && penable;
	assign pready = access;
	assign wr_ok = access && pwrite && !pslverr;

	////////////////////
	// Decode and errors

	always_comb begin
		prdata = '0;
		pslverr = 1'b0;
		if (access) begin
			case (paddr)
				mdio_pkg::reg_cmd_addr: begin
					// Bit 15 reads as zero
					prdata = {16'h0000, 3'b000, reg_addr, 3'b000, phy_addr};
					pslverr = pwrite && busy;
				end
				mdio_pkg::reg_data: begin
					prdata = {16'h0000, rd_data};
					pslverr = pwrite && busy;
				end
				// Two copies of the busy flag
				// Writes here are dropped without error
				mdio_pkg::reg_status,
				mdio_pkg::reg_status2: begin
					prdata = {31'h0, busy};
				end
				default: begin
					pslverr = 1'b1;
				end
			endcase
		end
	end

	////////////////////
	// Command capture

	always_ff @(posedge apb or negedge arst_n) begin
		if (!arst_n) begin
			start_read <= 1'b0;
			start_write <= 1'b0;
			phy_addr <= '0;
			reg_addr <= '0;
			cmd_op <= mdio_pkg::op_read;
		end else begin
			// Strobes last one cycle
			start_read <= 1'b0;
			start_write <= 1'b0;
			if (wr_ok && (paddr == mdio_pkg::reg_cmd_addr)) begin
				phy_addr <= pwdata[4:0];
				reg_addr <= pwdata[12:8];
				// Bit 15 set only stages a write
				if (!pwdata[15]) begin
					start_read <= 1'b1;
					cmd_op <= mdio_pkg::op_read;
				end
			end
			if (wr_ok && (paddr == mdio_pkg::reg_data)) begin
				start_write <= 1'b1;
				cmd_op <= mdio_pkg::op_write;
			end
		end
	end

	// Write data
	always_ff @(posedge apb) begin
		if (wr_ok && (paddr == mdio_pkg::reg_data))
			wr_data <= pwdata[mdio_pkg::reg_data_width-1:0];
	end

	////////////////////
	// Frame build

	always_comb begin
		frame.fields.start = mdio_pkg::start_code;
		frame.fields.op = cmd_op;
		frame.fields.phy_addr = phy_addr;
		frame.fields.reg_addr = reg_addr;
		frame.fields.ta = mdio_pkg::ta_code;
		// PHY owns the wire for read data
		frame.fields.data = wr_data;
	end

	////////////////////
	// Checks

	// Access phase follows a setup phase
	a_pready_setup: assert property (@(posedge apb) disable iff (!arst_n)
		pready |-> $past(psel && !penable));

endmodule

// ==== logic/apb_mdio_top.sv ====
`timescale 1ns/100ps

module apb_mdio_top (
	input logic apb,
	input logic arst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [mdio_pkg::addr_width-1:0] paddr,
	input logic [mdio_pkg::data_width-1:0] pwdata,
	output logic [mdio_pkg::data_width-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic mdc,
	output logic mdio_out,
	output logic mdio_oe,
	input logic mdio_in
);

	// Register block to engine
	mdio_pkg::mdio_frame_u frame;
	logic start_read;
	logic start_write;
	logic busy;
	logic [mdio_pkg::reg_data_width-1:0] rd_data;

	// Engine internals
	logic restart;
	logic mdc_rise;
	logic mdc_fall;
	logic load;
	logic shift;
	logic capture;

	////////////////////
	// APB side

	apb_mdio_regs u_regs (
		.apb(apb),
		.arst_n(arst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.busy(busy),
		.rd_data(rd_data),
		.frame(frame),
		.start_read(start_read),
		.start_write(start_write)
	);

	////////////////////
	// MDIO engine

	mdio_frame_fsm u_fsm (
		.apb(apb),
		.arst_n(arst_n),
		.start_read(start_read),
		.start_write(start_write),
		.mdc_rise(mdc_rise),
		.mdc_fall(mdc_fall),
		.restart(restart),
		.busy(busy),
		.load(load),
		.shift(shift),
		.capture(capture),
		.mdio_oe(mdio_oe)
	);

	mdio_clock_divider u_divider (
		.apb(apb),
		.arst_n(arst_n),
		.restart(restart),
		.mdc(mdc),
		.mdc_rise(mdc_rise),
		.mdc_fall(mdc_fall)
	);

	mdio_shift_reg u_shift (
		.apb(apb),
		.arst_n(arst_n),
		.frame(frame),
		.load(load),
		.shift(shift),
		.capture(capture),
		.mdio_in(mdio_in),
		.mdio_out(mdio_out),
		.rd_data(rd_data)
	);

endmodule

// ==== tests/mdio_phy_model.sv ====
`timescale 1ns/100ps

module mdio_phy_model (
	input logic mdc,
	input logic mdio_out,
	input logic mdio_oe,
	output logic mdio_in
);

	// Only this PHY answers
	localparam logic [4:0] own_phy = 5'd5;

	logic [15:0] regs [0:31];
	// Current frame bits with the newest at bit 0
	mdio_pkg::mdio_frame_u rx;
	// Header view once 14 bits are in
	mdio_pkg::mdio_frame_u hdr;
	// Samples taken since the start bit
	int cnt;
	logic answering;
	// Read opcode seen in the header, any PHY address
	logic rd_frame;
	logic [15:0] tx_word;
	// Value on the shared wire
	logic line_bit;

	// MAC drives while oe is high and the PHY otherwise
	assign line_bit = mdio_oe ? mdio_out : mdio_in;
	assign hdr.raw = rx.raw << 18;

	initial begin
		for (int i = 0; i < 32; i++)
			regs[i] = 16'(i * 32'h1111);
		rx.raw = '1;
		cnt = 0;
		answering = 1'b0;
		rd_frame = 1'b0;
		tx_word = '0;
		mdio_in = 1'b1;
	end

	////////////////////
	// Sample on MDC rise

	always @(posedge mdc) begin
		mdio_pkg::mdio_frame_u full;
		full.raw = {rx.raw[30:0], line_bit};
		if (cnt == 0) begin
			// First zero after the preamble is the start bit
			if (line_bit == 1'b0) begin
				rx <= full;
				cnt <= 1;
			end
		end else if (cnt == 31) begin
			// Whole frame in
			if ((full.fields.op == mdio_pkg::op_write) && (full.fields.phy_addr == own_phy))
				regs[full.fields.reg_addr] <= full.fields.data;
			rx <= full;
			cnt <= 0;
		end else begin
			rx <= full;
			cnt <= cnt + 1;
		end
	end

	////////////////////
	// Drive on MDC fall

	always @(negedge mdc) begin
		if (cnt == 14) begin
			// TA0 left to the pull-up once the header is in
			answering <= (hdr.fields.op == mdio_pkg::op_read) &&
				(hdr.fields.phy_addr == own_phy);
			rd_frame <= (hdr.fields.op == mdio_pkg::op_read);
			tx_word <= regs[hdr.fields.reg_addr];
			mdio_in <= 1'b1;
		end else if (cnt == 15) begin
			// TA1 pulled low by the PHY
			mdio_in <= !answering;
		end else if ((cnt >= 16) && answering) begin
			mdio_in <= tx_word[15];
			tx_word <= {tx_word[14:0], 1'b0};
		end else begin
			mdio_in <= 1'b1;
		end
	end

endmodule

// ==== tests/tb_apb_mdio.sv ====
`timescale 1ns/100ps

module tb_apb_mdio;

	// Status reads before giving up on busy
	localparam int poll_limit = 400;

	logic apb;
	logic arst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [mdio_pkg::addr_width-1:0] paddr;
	logic [mdio_pkg::data_width-1:0] pwdata;
	logic [mdio_pkg::data_width-1:0] prdata;
	logic pready;
	logic pslverr;
	logic mdc;
	logic mdio_out;
	logic mdio_oe;
	logic mdio_in;

	// One entry per stimulus line
	byte ops [$];
	logic [mdio_pkg::addr_width-1:0] offs [$];
	logic [mdio_pkg::data_width-1:0] vals [$];
	logic [mdio_pkg::data_width-1:0] exp_datas [$];
	logic exp_errs [$];
	logic loaded;

	apb_mdio_top u_apb_mdio_top (
		.apb(apb),
		.arst_n(arst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.mdc(mdc),
		.mdio_out(mdio_out),
		.mdio_oe(mdio_oe),
		.mdio_in(mdio_in)
	);

	mdio_phy_model u_phy (
		.mdc(mdc),
		.mdio_out(mdio_out),
		.mdio_oe(mdio_oe),
		.mdio_in(mdio_in)
	);

	// 8 ns period
	always #4 apb = ~apb;

	////////////////////
	// Failure and compare

	task automatic abort_run();
		$display("test failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_prdata(input logic [mdio_pkg::data_width-1:0] got,
		input logic [mdio_pkg::data_width-1:0] exp);
		if (got !== exp) begin
			$display("Fail prdata got %h expected %h", got, exp);
			abort_run();
		end
	endtask

	task automatic check_slverr(input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail pslverr got %h expected %h", got, exp);
			abort_run();
		end
	endtask

	task automatic check_oe(input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail mdio_oe got %h expected %h", got, exp);
			abort_run();
		end
	endtask

	task automatic check_phy_reg(input logic [4:0] idx,
		input logic [mdio_pkg::reg_data_width-1:0] exp);
		logic [mdio_pkg::reg_data_width-1:0] got;
		got = u_phy.regs[idx];
		if (got !== exp) begin
			$display("Fail phy_reg[%h] got %h expected %h", idx, got, exp);
			abort_run();
		end
	endtask

	////////////////////
	// MDIO output enable

	// The MAC drives preamble and header
	// In a read frame the PHY owns the wire from turnaround on
	always @(posedge mdc) begin
		if (arst_n) begin
			if ((u_phy.cnt >= 14) && u_phy.rd_frame)
				check_oe(mdio_oe, 1'b0);
			else
				check_oe(mdio_oe, 1'b1);
		end
	end

	////////////////////
	// APB

	// Setup, access, then one idle cycle
	task automatic apb_access(input logic write, input logic [mdio_pkg::addr_width-1:0] addr,
		input logic [mdio_pkg::data_width-1:0] wdata,
		output logic [mdio_pkg::data_width-1:0] rdata, output logic err);
		int waits;
		@(posedge apb);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(posedge apb);
		#1;
		penable = 1'b1;
		waits = 0;
		// Sample mid-cycle where outputs are settled
		@(negedge apb);
		while (!pready) begin
			waits++;
			if (waits > 16) begin
				$display("APB completer never raised pready");
				abort_run();
			end
			@(negedge apb);
		end
		rdata = prdata;
		err = pslverr;
		@(posedge apb);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	// Read status until the engine is idle
	task automatic poll_idle(input logic [mdio_pkg::addr_width-1:0] addr);
		logic [mdio_pkg::data_width-1:0] rdata;
		logic err;
		int polls;
		polls = 0;
		apb_access(1'b0, addr, '0, rdata, err);
		check_slverr(err, 1'b0);
		while (rdata != '0) begin
			polls++;
			if (polls >= poll_limit) begin
				$display("Busy never cleared after %0d status reads", polls);
				abort_run();
			end
			apb_access(1'b0, addr, '0, rdata, err);
			check_slverr(err, 1'b0);
		end
	endtask

	////////////////////
	// Stimulus file

	task automatic load_stimulus();
		int fd;
		int c;
		int n;
		logic [31:0] f_off;
		logic [31:0] f_val;
		logic [31:0] f_exp;
		logic [31:0] f_err;
		logic [8*256-1:0] skip_text;
		fd = $fopen("tests/mdio_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Cannot open tests/mdio_stimulus.txt");
			abort_run();
		end
		c = $fgetc(fd);
		while (c != -1) begin
			if (c == int'("#")) begin
				n = $fgets(skip_text, fd);
			end else if ((c == int'("W")) || (c == int'("R")) || (c == int'("P")) ||
				(c == int'("M"))) begin
				n = $fscanf(fd, "%h %h %h %h", f_off, f_val, f_exp, f_err);
				if (n != 4) begin
					$display("Stimulus line %0d has missing fields", ops.size() + 1);
					abort_run();
				end
				ops.push_back(byte'(c));
				offs.push_back(f_off[mdio_pkg::addr_width-1:0]);
				vals.push_back(f_val);
				exp_datas.push_back(f_exp);
				exp_errs.push_back(f_err[0]);
			end else if ((c != int'(" ")) && (c != int'("\n")) && (c != int'("\r")) &&
				(c != int'("\t"))) begin
				$display("Unknown operation letter in the stimulus file");
				abort_run();
			end
			c = $fgetc(fd);
		end
		$fclose(fd);
	endtask

	////////////////////
	// Main sequence

	initial begin
		logic [mdio_pkg::data_width-1:0] rdata;
		logic err;
		apb = 1'b0;
		arst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		loaded = 1'b0;
		load_stimulus();
		loaded = 1'b1;
		repeat (8) @(posedge apb);
		#1;
		arst_n = 1'b1;
		for (int i = 0; i < ops.size(); i++) begin
			case (ops[i])
				"W": begin
					apb_access(1'b1, offs[i], vals[i], rdata, err);
					check_slverr(err, exp_errs[i]);
				end
				"R": begin
					apb_access(1'b0, offs[i], '0, rdata, err);
					check_prdata(rdata, exp_datas[i]);
					check_slverr(err, exp_errs[i]);
				end
				"P": begin
					poll_idle(offs[i]);
				end
				default: begin
					// Model register against expected word
					check_phy_reg(offs[i][4:0], exp_datas[i][mdio_pkg::reg_data_width-1:0]);
				end
			endcase
		end
		$display("test passed");
		$finish;
	end

	// Watchdog allows 700 cycles per stimulus line
	initial begin
		longint limit_ns;
		wait (loaded);
		limit_ns = longint'(ops.size()) * 700 * 8;
		#(limit_ns);
		$display("Watchdog expired before the stimulus finished");
		abort_run();
	end

endmodule

// ==== tests/mdio_stimulus.txt ====
# op offset value exp_data exp_err, all hex
# W write, R read, P poll STATUS until idle, M check model register (offset is reg address)
R 40 0 0 0
R 60 0 0 0
R 00 0 0 0
W 00 0305 0 0
R 40 0 1 0
P 40 0 0 0
R 20 0 3333 0
W 00 8905 0 0
R 00 0 0905 0
W 20 BEEF 0 0
P 40 0 0 0
M 09 0 BEEF 0
W 00 0905 0 0
P 40 0 0 0
R 20 0 BEEF 0
W 00 0305 0 0
R 60 0 1 0
W 00 8A05 0 1
W 20 1234 0 1
P 40 0 0 0
R 00 0 0305 0
R 20 0 3333 0
M 03 0 3333 0
M 0A 0 AAAA 0
R 10 0 0 1
W 10 1 0 1
R 80 0 0 1
W 80 1 0 1
W 40 5 0 0
R 40 0 0 0

// ==== all.f ====
logic/mdio_pkg.sv
logic/mdio_clock_divider.sv
logic/mdio_frame_fsm.sv
logic/mdio_shift_reg.sv
logic/apb_mdio_regs.sv
logic/apb_mdio_top.sv
tests/mdio_phy_model.sv
tests/tb_apb_mdio.sv

// ==== Makefile ====
TOOL      ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_apb_mdio
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
PASS_TEXT  = test passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

# Fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
